//--- verilog.f
+incdir+source
source/mem_read_pkg.sv
source/rd_tag_if.sv
source/sync_fifo.sv
source/read_request_issuer.sv
source/read_response_merger.sv
source/mem_read_path.sv
test/mem_read_path_tb.sv

//--- Makefile
# Verilator build for the read path testbench

TOOL       = verilator
TOP        = mem_read_path_tb
RTL_TOP    = mem_read_path
FILE_LIST  = verilog.f
FLAGS      = --timing --timescale 1ns/1ps
LINT_FLAGS = --lint-only
SIM_FLAGS  = --binary -j 0
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = STATUS: PASS

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) $(LINT_FLAGS) $(FLAGS) --top-module $(RTL_TOP) -f $(FILE_LIST)
	$(TOOL) $(LINT_FLAGS) $(FLAGS) --top-module $(TOP) -f $(FILE_LIST)

sim:
	$(TOOL) $(SIM_FLAGS) $(FLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILE_LIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- test/mem_read_path_tb.sv
// testbench for the read path: clock, reset, stimulus, memory model, reference and checker
`timescale 1ns/1ps
`include "mem_read_settings.svh"

module mem_read_path_tb;
    import mem_read_pkg::*;

    localparam int WAIT_LIMIT = 2000;

    // every DUT input starts at a known value
    logic        clk = 1'b0;
    logic        rst = 1'b1;
    logic        rd_req = 1'b0;
    mem_addr_t   rd_addr = '0;
    beat_count_t rd_size = '0;
    logic        mem_req_grant = 1'b0;
    logic        mem_resp_valid = 1'b0;
    beat_data_t  mem_resp_data = '0;
    logic        inbuf_full = 1'b0;
    logic        rd_ready;
    logic        mem_req_valid;
    mem_addr_t   mem_req_addr;
    logic        mem_resp_grant;
    logic        inbuf_push;
    beat_data_t  inbuf_data;
    mem_addr_t   inbuf_addr;

    // expected beats, filled by the stimulus
    mem_addr_t   exp_req[$];
    mem_addr_t   exp_push[$];

    // memory model: granted addresses and the cycle each may answer
    mem_addr_t   model_addr[$];
    int          model_due[$];
    int          last_due = 0;
    int          cycle = 0;
    logic        random_mode = 1'b0;
    logic [31:0] rng_state = 32'd55327;
    logic [31:0] drive_rand;
    logic [31:0] delay_rand;
    int          model_delay;
    int          model_ready;
    mem_addr_t   head_addr;

    // random macro reads, start address and beat count
    mem_addr_t   rand_start[16];
    int          rand_beats[16];

    // bookkeeping
    int          error_count = 0;
    int          check_count = 0;
    int          test_errors = 0;
    int          tests_passed = 0;
    int          tests_failed = 0;
    int          req_count = 0;
    int          push_count = 0;
    int          req_before;
    int          push_before;
    logic [31:0] r;
    mem_addr_t   start;

    mem_read_path mem_read_path_i (
        .clk            (clk),
        .rst            (rst),
        .rd_req         (rd_req),
        .rd_addr        (rd_addr),
        .rd_size        (rd_size),
        .rd_ready       (rd_ready),
        .mem_req_valid  (mem_req_valid),
        .mem_req_addr   (mem_req_addr),
        .mem_req_grant  (mem_req_grant),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_grant (mem_resp_grant),
        .inbuf_full     (inbuf_full),
        .inbuf_push     (inbuf_push),
        .inbuf_data     (inbuf_data),
        .inbuf_addr     (inbuf_addr)
    );

    always #2 clk = ~clk;

    // 32-bit xorshift step
    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] next_rand();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    // beat contents as a function of the whole address
    function automatic beat_data_t ref_data(input mem_addr_t a);
        return {a ^ 32'h5a5a_c3c3, (a * 32'h9e37_79b9) + 32'h0123_4567};
    endfunction

    task automatic compare(input string name, input logic [63:0] got, input logic [63:0] exp);
        check_count++;
        if (got !== exp) begin
            error_count++;
            $display("error: %s got %h expected %h", name, got, exp);
        end
    endtask

    task automatic report_failure(input string msg);
        error_count++;
        $display("failure: %s", msg);
    endtask

    task automatic start_test();
        test_errors = error_count;
    endtask

    task automatic end_test(input string name);
        if (error_count == test_errors) begin
            tests_passed++;
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, error_count - test_errors);
        end
    endtask

    // one-cycle rd_req strobe, expected beats queued up front
    task automatic post_read(input mem_addr_t addr, input int beats);
        int n;
        @(negedge clk);
        rd_req  = 1'b1;
        rd_addr = addr;
        rd_size = beat_count_t'(beats);
        for (int k = 0; k < beats; k++) begin
            exp_req.push_back(addr + mem_addr_t'(k * `BEAT_BYTES));
            exp_push.push_back(addr + mem_addr_t'(k * `BEAT_BYTES));
        end
        @(negedge clk);
        rd_req = 1'b0;
        for (n = 0; n < 8 && rd_ready; n++) begin
            @(negedge clk);
        end
        if (rd_ready) begin
            report_failure("rd_ready stayed high after a macro read was posted");
        end
    endtask

    // idle again once every expected beat reached the input buffer
    // rd_ready stays low while any beat is still outstanding
    task automatic wait_done();
        int   n;
        logic early;
        early = 1'b0;
        for (n = 0; n < WAIT_LIMIT && !(rd_ready && exp_push.size() == 0); n++) begin
            if (rd_ready && !early) begin
                early = 1'b1;
                report_failure("rd_ready rose while beats were still outstanding");
            end
            @(negedge clk);
        end
        if (!(rd_ready && exp_push.size() == 0)) begin
            report_failure("rd_ready did not return high after the last beat");
        end
        compare("unissued requests", 64'(exp_req.size()), 64'd0);
    endtask

    // inputs change on the falling edge only
    always @(negedge clk) begin
        cycle = cycle + 1;
        if (random_mode) begin
            drive_rand    = next_rand();
            mem_req_grant = (drive_rand[1:0] != 2'b00);
            inbuf_full    = (drive_rand[9:8] == 2'b00);
        end else begin
            mem_req_grant = 1'b1;
            inbuf_full    = 1'b0;
        end
        // in-order answer once the head is due
        if (!rst && model_addr.size() > 0 && model_due[0] <= cycle) begin
            mem_resp_valid = 1'b1;
            mem_resp_data  = ref_data(model_addr[0]);
        end else begin
            mem_resp_valid = 1'b0;
            mem_resp_data  = '0;
        end
    end

    // memory side: granted requests and accepted responses
    always @(posedge clk) begin
        if (!rst && mem_req_valid && mem_req_grant) begin
            req_count++;
            if (exp_req.size() == 0) begin
                report_failure("memory request granted with no beat outstanding");
            end else begin
                head_addr = exp_req.pop_front();
                compare("mem_req_addr", 64'(mem_req_addr), 64'(head_addr));
            end
            delay_rand  = next_rand();
            model_delay = random_mode ? int'(delay_rand % 32'd5) + 1 : 1;
            // due cycles never go backwards, so answers stay in order
            model_ready = cycle + model_delay;
            if (model_ready < last_due) begin
                model_ready = last_due;
            end
            last_due = model_ready;
            model_addr.push_back(mem_req_addr);
            model_due.push_back(model_ready);
        end
        if (!rst && mem_resp_grant && !mem_resp_valid) begin
            report_failure("response grant raised with no valid response");
        end
        if (!rst && mem_resp_valid && mem_resp_grant) begin
            void'(model_addr.pop_front());
            void'(model_due.pop_front());
        end
    end

    // input buffer checker
    always @(posedge clk) begin
        if (!rst && inbuf_push && inbuf_full) begin
            report_failure("input buffer pushed while it was full");
        end
        if (!rst && inbuf_push) begin
            push_count++;
            if (exp_push.size() == 0) begin
                report_failure("input buffer push with no beat outstanding");
            end else begin
                start = exp_push.pop_front();
                compare("inbuf_addr", 64'(inbuf_addr), 64'(start));
                compare("inbuf_data", inbuf_data, ref_data(start));
            end
        end
    end

    // last resort if a loop bound is ever missed
    initial begin
        #1_000_000;
        $display("failure: simulation ran past its time limit");
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        repeat (5) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        start_test();
        compare("mem_req_valid", 64'(mem_req_valid), 64'd0);
        compare("mem_resp_grant", 64'(mem_resp_grant), 64'd0);
        compare("inbuf_push", 64'(inbuf_push), 64'd0);
        compare("rd_ready", 64'(rd_ready), 64'd1);
        end_test("reset values");

        start_test();
        post_read(32'h0000_1000, 6);
        wait_done();
        end_test("single read");

        // zero beats: consumed, nothing issued
        start_test();
        req_before  = req_count;
        push_before = push_count;
        post_read(32'h0000_2000, 0);
        wait_done();
        repeat (8) @(negedge clk);
        compare("requests for zero size", 64'(req_count - req_before), 64'd0);
        compare("pushes for zero size", 64'(push_count - push_before), 64'd0);
        compare("rd_ready", 64'(rd_ready), 64'd1);
        end_test("zero size");

        // two macro reads in flight, random stalls everywhere
        start_test();
        for (int i = 0; i < 16; i++) begin
            r             = next_rand();
            rand_start[i] = r & 32'hffff_fff8;
            r             = next_rand();
            rand_beats[i] = int'(r % 32'd20) + 1;
        end
        @(posedge clk);
        random_mode = 1'b1;
        for (int i = 0; i < 8; i++) begin
            post_read(rand_start[2*i], rand_beats[2*i]);
            post_read(rand_start[2*i+1], rand_beats[2*i+1]);
            wait_done();
        end
        random_mode = 1'b0;
        end_test("random reads");

        $display("tests passed %0d, failed %0d, checks %0d, errors %0d",
                 tests_passed, tests_failed, check_count, error_count);
        if (error_count == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- source/mem_read_path.sv
// read path top level: request issuer, response merger and rd_ready
`timescale 1ns/1ps

module mem_read_path (
    input  logic                      clk,
    input  logic                      rst,

    // client side macro reads
    input  logic                      rd_req,
    input  mem_read_pkg::mem_addr_t   rd_addr,
    input  mem_read_pkg::beat_count_t rd_size,
    output logic                      rd_ready,

    // memory request port
    output logic                      mem_req_valid,
    output mem_read_pkg::mem_addr_t   mem_req_addr,
    input  logic                      mem_req_grant,

    // memory response port
    input  logic                      mem_resp_valid,
    input  mem_read_pkg::beat_data_t  mem_resp_data,
    output logic                      mem_resp_grant,

    // accelerator input buffer
    input  logic                      inbuf_full,
    output logic                      inbuf_push,
    output mem_read_pkg::beat_data_t  inbuf_data,
    output mem_read_pkg::mem_addr_t   inbuf_addr
);

    // beat tags and busy status between the two halves
    rd_tag_if tag_if ();

    // macro queue, sequencer, request queue
    read_request_issuer issuer_i (
        .clk           (clk),
        .rst           (rst),
        .rd_req        (rd_req),
        .rd_addr       (rd_addr),
        .rd_size       (rd_size),
        .mem_req_valid (mem_req_valid),
        .mem_req_addr  (mem_req_addr),
        .mem_req_grant (mem_req_grant),
        .tag           (tag_if.issuer)
    );

    // response queue, tag queue, merge
    read_response_merger merger_i (
        .clk            (clk),
        .rst            (rst),
        .mem_resp_valid (mem_resp_valid),
        .mem_resp_data  (mem_resp_data),
        .mem_resp_grant (mem_resp_grant),
        .inbuf_full     (inbuf_full),
        .inbuf_push     (inbuf_push),
        .inbuf_data     (inbuf_data),
        .inbuf_addr     (inbuf_addr),
        .tag            (tag_if.merger)
    );

    // idle only when nothing is queued, sequenced or awaiting a response
    // an empty tag queue also means an empty response queue,
    // since every response belongs to a beat whose tag is still held
    assign rd_ready = !tag_if.pending && tag_if.empty;

endmodule

//--- source/read_response_merger.sv
// response and tag queues, merged into input buffer writes
`timescale 1ns/1ps
`include "mem_read_settings.svh"

module read_response_merger (
    input  logic                     clk,
    input  logic                     rst,

    // in-order responses from memory
    input  logic                     mem_resp_valid,
    input  mem_read_pkg::beat_data_t mem_resp_data,
    output logic                     mem_resp_grant,

    // accelerator input buffer
    input  logic                     inbuf_full,
    output logic                     inbuf_push,
    output mem_read_pkg::beat_data_t inbuf_data,
    output mem_read_pkg::mem_addr_t  inbuf_addr,

    // beat tags from the issuer
    rd_tag_if.merger                 tag
);

    logic resp_push;
    logic resp_empty;
    logic resp_full;
    logic merge;

    // response accepted whenever there is room
    assign resp_push      = mem_resp_valid && !resp_full;
    assign mem_resp_grant = resp_push;

    sync_fifo #(
        .WIDTH     (`MEM_DATA_W),
        .LOG_DEPTH (`RESP_Q_LOG_DEPTH)
    ) resp_q (
        .clk   (clk),
        .rst   (rst),
        .push  (resp_push),
        .pop   (merge),
        .din   (mem_resp_data),
        .dout  (inbuf_data),
        .full  (resp_full),
        .empty (resp_empty)
    );

    // one tag per issued beat, same order as responses
    sync_fifo #(
        .WIDTH     (`MEM_ADDR_W),
        .LOG_DEPTH (`TAG_Q_LOG_DEPTH)
    ) tag_q (
        .clk   (clk),
        .rst   (rst),
        .push  (tag.push),
        .pop   (merge),
        .din   (tag.addr),
        .dout  (inbuf_addr),
        .full  (tag.full),
        .empty (tag.empty)
    );

    // both heads present and buffer has room
    // pops of both queues land at the next edge
    assign merge      = !tag.empty && !resp_empty && !inbuf_full;
    assign inbuf_push = merge;

endmodule

//--- source/read_request_issuer.sv
// macro read queue, beat sequencer and memory request queue
`timescale 1ns/1ps
`include "mem_read_settings.svh"

module read_request_issuer (
    input  logic                      clk,
    input  logic                      rst,

    // macro read from the client
    input  logic                      rd_req,
    input  mem_read_pkg::mem_addr_t   rd_addr,
    input  mem_read_pkg::beat_count_t rd_size,

    // single-beat requests to memory
    output logic                      mem_req_valid,
    output mem_read_pkg::mem_addr_t   mem_req_addr,
    input  logic                      mem_req_grant,

    // beat tags toward the merger
    rd_tag_if.issuer                  tag
);
    import mem_read_pkg::*;

    localparam int MACRO_W = `MEM_ADDR_W + `BEAT_COUNT_W;

    // macro queue
    logic               macro_push;
    logic               macro_pop;
    logic [MACRO_W-1:0] macro_din;
    logic [MACRO_W-1:0] macro_dout;
    logic               macro_full;
    logic               macro_empty;
    mem_addr_t          macro_addr;
    beat_count_t        macro_size;

    // request queue
    logic               req_push;
    logic               req_pop;
    mem_addr_t          req_dout;
    logic               req_full;
    logic               req_empty;

    // sequencer
    issue_state_t       state;
    mem_addr_t          cur_addr;
    beat_count_t        beats_left;
    logic               issue_beat;

    // no back-pressure toward the client beyond rd_ready
    assign macro_push = rd_req && !macro_full;
    assign macro_din  = {rd_addr, rd_size};
    assign {macro_addr, macro_size} = macro_dout;

    sync_fifo #(
        .WIDTH     (MACRO_W),
        .LOG_DEPTH (`MACRO_Q_LOG_DEPTH)
    ) macro_q (
        .clk   (clk),
        .rst   (rst),
        .push  (macro_push),
        .pop   (macro_pop),
        .din   (macro_din),
        .dout  (macro_dout),
        .full  (macro_full),
        .empty (macro_empty)
    );

    // take next macro read only when idle
    assign macro_pop = (state == ISSUE_IDLE) && !macro_empty;

    // one beat per cycle, needs room in both req and tag queues
    assign issue_beat = (state == ISSUE_BEATS) && !req_full && !tag.full;

    always_ff @(posedge clk) begin
        if (rst) begin
            state      <= ISSUE_IDLE;
            beats_left <= '0;
        end else begin
            case (state)
                ISSUE_IDLE: begin
                    if (macro_pop) begin
                        beats_left <= macro_size;
                        // zero-beat read is consumed with no beats
                        if (macro_size != '0) begin
                            state <= ISSUE_BEATS;
                        end
                    end
                end
                ISSUE_BEATS: begin
                    if (issue_beat) begin
                        beats_left <= beats_left - 1'b1;
                        if (beats_left == beat_count_t'(1)) begin
                            state <= ISSUE_IDLE;
                        end
                    end
                end
                default: state <= ISSUE_IDLE;
            endcase
        end
    end

    // beat address, loaded on pop and stepped per beat
    always_ff @(posedge clk) begin
        if (macro_pop) begin
            cur_addr <= macro_addr;
        end else if (issue_beat) begin
            cur_addr <= cur_addr + mem_addr_t'(`BEAT_BYTES);
        end
    end

    // same address goes to memory and to the tag queue
    assign req_push = issue_beat;
    assign tag.push = issue_beat;
    assign tag.addr = cur_addr;

    sync_fifo #(
        .WIDTH     (`MEM_ADDR_W),
        .LOG_DEPTH (`REQ_Q_LOG_DEPTH)
    ) req_q (
        .clk   (clk),
        .rst   (rst),
        .push  (req_push),
        .pop   (req_pop),
        .din   (cur_addr),
        .dout  (req_dout),
        .full  (req_full),
        .empty (req_empty)
    );

    // memory port driven straight from the queue head
    assign mem_req_valid = !req_empty;
    assign mem_req_addr  = req_dout;
    assign req_pop       = mem_req_valid && mem_req_grant;

    // anything still to issue or still waiting for a grant
    assign tag.pending = !macro_empty || !req_empty || (state != ISSUE_IDLE);

endmodule

//--- source/sync_fifo.sv
// synchronous show-ahead FIFO with full and empty flags
`timescale 1ns/1ps

module sync_fifo #(
    parameter int WIDTH     = 8,
    parameter int LOG_DEPTH = 2
) (
    input  logic             clk,
    input  logic             rst,
    input  logic             push,
    input  logic             pop,
    input  logic [WIDTH-1:0] din,
    output logic [WIDTH-1:0] dout,
    output logic             full,
    output logic             empty
);

    localparam int DEPTH = 2 ** LOG_DEPTH;

    logic [WIDTH-1:0]     mem [DEPTH];
    logic [LOG_DEPTH-1:0] wr_ptr;
    logic [LOG_DEPTH-1:0] rd_ptr;
    logic [LOG_DEPTH:0]   count;
    logic                 do_push;
    logic                 do_pop;

    // illegal push or pop simply dropped here
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;

    assign full  = (count == (LOG_DEPTH + 1)'(DEPTH));
    assign empty = (count == '0);

    // head entry, valid while not empty
    assign dout = mem[rd_ptr];

    // storage
    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= din;
        end
    end

    // pointers wrap on their own width
    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (do_pop) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

endmodule

//--- source/rd_tag_if.sv
// beat tag interface between the request issuer and the response merger
`timescale 1ns/1ps

interface rd_tag_if;
    import mem_read_pkg::*;

    // one tag per issued beat
    logic      push;
    mem_addr_t addr;

    // tag queue flags, owned by the merger
    logic      full;
    logic      empty;

    // issuer still has work queued or in flight
    logic      pending;

    modport issuer (
        output push,
        output addr,
        output pending,
        input  full
    );

    modport merger (
        input  push,
        input  addr,
        output full,
        output empty
    );

endinterface

//--- source/mem_read_pkg.sv
// read path types: address, beat count, beat data and sequencer states
`include "mem_read_settings.svh"

package mem_read_pkg;

    // byte address on the memory port
    typedef logic [`MEM_ADDR_W-1:0] mem_addr_t;

    // number of beats in a macro read
    typedef logic [`BEAT_COUNT_W-1:0] beat_count_t;

    // one beat of data
    typedef logic [`MEM_DATA_W-1:0] beat_data_t;

    // sequencer states
    // idle waits on the macro queue
    // beats walks through the current macro read
    typedef enum logic {
        ISSUE_IDLE  = 1'b0,
        ISSUE_BEATS = 1'b1
    } issue_state_t;

endpackage

//--- source/mem_read_settings.svh
// width, beat step and queue depth macros for the read path
`ifndef MEM_READ_SETTINGS_SVH
`define MEM_READ_SETTINGS_SVH

// byte address width
`define MEM_ADDR_W 32

// beat count of one macro read
`define BEAT_COUNT_W 10

// one beat of memory data
`define MEM_DATA_W 64

// bytes per beat, also the address step
`define BEAT_BYTES 8

// log2 of queue depths
`define MACRO_Q_LOG_DEPTH 2
`define TAG_Q_LOG_DEPTH 3
`define REQ_Q_LOG_DEPTH 2
`define RESP_Q_LOG_DEPTH 3

`endif
